// ==== verilog/bpu_cfg_pkg.sv ====
`default_nettype none

package bpu_cfg_pkg;

  // table sizing
  localparam int INDEX_LEN   = 6;
  localparam int INDEX_DEPTH = 1 << INDEX_LEN;
  localparam int TAG_LEN     = 7;

  // pattern table index is {pc bits, local history}
  localparam int HIST_LEN   = 4;
  localparam int CNT_PC_LEN = 4;
  localparam int CNT_DEPTH  = 1 << (CNT_PC_LEN + HIST_LEN);

  // return address stack
  localparam int RAS_DEPTH   = 8;
  localparam int RAS_PTR_LEN = $clog2(RAS_DEPTH);

  // first fetch address out of reset
  localparam logic [31:0] RESET_PC = 32'h1c000000;

endpackage

`default_nettype wire

// ==== verilog/bpu_types_pkg.sv ====
`default_nettype none

package bpu_types_pkg;

  import bpu_cfg_pkg::*;

  // what a slot's branch resolves to
  typedef enum logic [1:0] {
    TGT_NPC    = 2'd0,
    TGT_IMM    = 2'd1,
    TGT_CALL   = 2'd2,
    TGT_RETURN = 2'd3
  } bpu_target_e;

  typedef struct packed {
    bpu_target_e         target_type;
    logic                cond;
    logic [HIST_LEN-1:0] history;
    logic [TAG_LEN-1:0]  tag;
  } branch_info_t;

  // one record per fetch slot, carried down the pipe
  typedef struct packed {
    logic                   taken;
    logic                   tid;
    logic [31:0]            predict_pc;
    logic [1:0]             cnt;
    logic [HIST_LEN-1:0]    history;
    bpu_target_e            target_type;
    logic                   cond;
    logic [RAS_PTR_LEN-1:0] ras_ptr;
  } bpu_predict_t;

  // feedback from the back end
  typedef struct packed {
    logic                   redirect;
    logic                   tid;
    logic                   need_update;
    logic                   miss;
    logic                   ras_repair;
    logic [31:0]            pc;
    logic [31:0]            true_target;
    logic                   true_taken;
    logic                   true_cond;
    bpu_target_e            true_type;
    logic [HIST_LEN-1:0]    history;
    logic [1:0]             cnt;
    logic [RAS_PTR_LEN-1:0] ras_ptr;
  } bpu_correct_t;

  // 2-bit counter step, strong states need two misses to flip
  function automatic logic [1:0] next_cnt(input logic [1:0] cnt, input logic taken);
    logic [1:0] nxt;
    case (cnt)
      2'b00:   nxt = {1'b0, taken};
      2'b01:   nxt = {taken, 1'b0};
      2'b10:   nxt = {taken, 1'b1};
      default: nxt = {1'b1, taken};
    endcase
    return nxt;
  endfunction

  function automatic logic [INDEX_LEN-1:0] index_of(input logic [31:0] pc);
    return pc[INDEX_LEN+2:3] ^ pc[2*INDEX_LEN+2:INDEX_LEN+3];
  endfunction

  function automatic logic [TAG_LEN-1:0] tag_of(input logic [31:0] pc);
    return pc[TAG_LEN+11:12];
  endfunction

endpackage

`default_nettype wire

// ==== verilog/bpu_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_table
  import bpu_cfg_pkg::*;
#(
  parameter type payload_t = logic [29:0]
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rd_en_i,
  input  logic [INDEX_LEN-1:0] rd_addr_i,
  output payload_t             rd_data_o,
  input  logic                 wr_en_i,
  input  logic [INDEX_LEN-1:0] wr_addr_i,
  input  payload_t             wr_data_i,
  input  logic                 hold_i
);

  payload_t mem_q [INDEX_DEPTH];
  payload_t rd_data_q;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // hold_i forces a reload even while the fetch is stalled
  // same-address write in this cycle is not seen yet
  always_ff @(posedge clk) begin
    if (rd_en_i || hold_i) begin
      rd_data_q <= mem_q[rd_addr_i];
    end
  end

  assign rd_data_o = rd_data_q;

  a_wr_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en_i |-> !$isunknown(wr_addr_i)
  );

endmodule

`default_nettype wire

// ==== verilog/pattern_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_table
  import bpu_cfg_pkg::*, bpu_types_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [31:0]              rd_pc_i,
  input  logic [1:0][HIST_LEN-1:0] rd_hist_i,
  output logic [1:0][1:0]          cnt_o,
  input  bpu_correct_t             corr_i
);

  localparam int CNT_IDX_LEN = CNT_PC_LEN + HIST_LEN;

  logic [CNT_DEPTH-1:0][1:0] cnt_q;
  logic                      cnt_we;
  logic [CNT_IDX_LEN-1:0]    cnt_waddr;
  logic [1:0]                cnt_wdata;

  // only conditional branches train the counters
  assign cnt_we    = corr_i.need_update && corr_i.true_cond;
  assign cnt_waddr = {corr_i.pc[CNT_PC_LEN+2:3], corr_i.history};
  assign cnt_wdata = next_cnt(corr_i.cnt, corr_i.true_taken);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (cnt_we) begin
      cnt_q[cnt_waddr] <= cnt_wdata;
    end
  end

  // both slots share the pc bits, history differs per slot
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      cnt_o[p] = cnt_q[{rd_pc_i[CNT_PC_LEN+2:3], rd_hist_i[p]}];
    end
  end

  a_cnt_only_on_update: assert property (
    @(posedge clk) disable iff (!rst_n)
    !corr_i.need_update |=> $stable(cnt_q)
  );

endmodule

`default_nettype wire

// ==== verilog/return_stack.sv ====
`timescale 1ns/1ps
`default_nettype none

module return_stack
  import bpu_cfg_pkg::*, bpu_types_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_i,
  input  logic                   pop_i,
  input  logic [31:0]            push_addr_i,
  input  bpu_correct_t           corr_i,
  output logic [31:0]            top_o,
  output logic [RAS_PTR_LEN-1:0] ptr_o
);

  logic [RAS_DEPTH-1:0][31:0] stack_q;
  logic [RAS_PTR_LEN-1:0]     ptr_q;
  logic [RAS_PTR_LEN-1:0]     wptr_q;
  logic [31:0]                top_q;
  logic                       repair;

  assign repair = corr_i.miss || corr_i.ras_repair;

  // pointers, repair overrides speculative push and pop
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q  <= '0;
      wptr_q <= RAS_PTR_LEN'(1);
    end else if (repair) begin
      ptr_q  <= corr_i.ras_ptr;
      wptr_q <= corr_i.ras_ptr + 1'b1;
    end else if (push_i) begin
      ptr_q  <= ptr_q + 1'b1;
      wptr_q <= wptr_q + 1'b1;
    end else if (pop_i) begin
      ptr_q  <= ptr_q - 1'b1;
      wptr_q <= wptr_q - 1'b1;
    end
  end

  // entries
  always_ff @(posedge clk) begin
    if (repair) begin
      if (corr_i.true_type == TGT_CALL) begin
        stack_q[corr_i.ras_ptr] <= corr_i.pc + 32'd4;
      end
    end else if (push_i) begin
      stack_q[wptr_q] <= push_addr_i;
    end
  end

  // registered top, one cycle behind the pointer
  always_ff @(posedge clk) begin
    top_q <= stack_q[ptr_q];
  end

  assign top_o = top_q;
  assign ptr_o = ptr_q;

  a_wptr_follows_ptr: assert property (
    @(posedge clk) disable iff (!rst_n)
    (push_i || pop_i || repair) |=> (wptr_q == ptr_q + 1'b1)
  );

endmodule

`default_nettype wire

// ==== verilog/fetch_pc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_ctrl
  import bpu_cfg_pkg::*, bpu_types_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ready_i,
  input  bpu_correct_t              corr_i,
  input  logic [1:0][31:0]          target_i,
  input  branch_info_t [1:0]        info_i,
  input  logic [1:0][1:0]           cnt_i,
  input  logic [31:0]               ras_top_i,
  input  logic [RAS_PTR_LEN-1:0]    ras_ptr_i,
  output logic [31:0]               npc_o,
  output logic                      rd_en_o,
  output logic [1:0][HIST_LEN-1:0]  hist_o,
  output logic [1:0]                info_we_o,
  output logic [1:0][INDEX_LEN-1:0] info_waddr_o,
  output branch_info_t [1:0]        info_wdata_o,
  output logic                      push_o,
  output logic                      pop_o,
  output logic [31:0]               push_addr_o,
  output logic                      valid_o,
  output logic [31:0]               pc_o,
  output logic [1:0]                mask_o,
  output bpu_predict_t [1:0]        predict_o
);

  logic        tid_q;
  logic [31:0] pc_q;
  logic [31:0] pc_base;
  logic [1:0]  hit;
  logic [1:0]  jump;
  logic [1:0]  slot_taken;
  bpu_target_e jump_type;
  logic        bundle_fire;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tid_q <= 1'b0;
    end else if (corr_i.redirect) begin
      tid_q <= corr_i.tid;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (ready_i) begin
      pc_q <= npc_o;
    end
  end

  assign pc_o        = pc_q;
  assign pc_base     = {pc_q[31:3], 3'b000};
  assign rd_en_o     = ready_i;
  assign bundle_fire = valid_o && ready_i;

  for (genvar p = 0; p < 2; p++) begin : g_slot
    assign hist_o[p] = info_i[p].history;
    assign hit[p]    = (info_i[p].target_type != TGT_NPC) &&
                       (info_i[p].tag == tag_of(pc_q));
    // unconditional and non-IMM branches always jump
    assign jump[p]   = hit[p] && ((info_i[p].target_type != TGT_IMM) ||
                                  !info_i[p].cond || cnt_i[p][1]);
  end

  // next pc, first jumping slot wins
  always_comb begin
    valid_o    = 1'b1;
    npc_o      = pc_base + 32'd8;
    mask_o     = {1'b1, !pc_q[2]};
    slot_taken = 2'b00;
    jump_type  = TGT_NPC;
    if (!pc_q[2] && jump[0]) begin
      slot_taken[0] = 1'b1;
      mask_o[1]     = 1'b0;
      jump_type     = info_i[0].target_type;
      npc_o         = (jump_type == TGT_RETURN) ? ras_top_i : target_i[0];
    end else if (jump[1]) begin
      slot_taken[1] = 1'b1;
      jump_type     = info_i[1].target_type;
      npc_o         = (jump_type == TGT_RETURN) ? ras_top_i : target_i[1];
    end
    if (corr_i.redirect) begin
      valid_o = 1'b0;
      npc_o   = corr_i.true_target;
    end
    // no bundle while in reset
    if (!rst_n) begin
      valid_o = 1'b0;
    end
  end

  // stack moves only when the bundle is accepted
  assign push_o      = bundle_fire && (jump_type == TGT_CALL);
  assign pop_o       = bundle_fire && (jump_type == TGT_RETURN);
  assign push_addr_o = pc_base + (slot_taken[0] ? 32'd4 : 32'd8);

  // info writes, correction beats speculative history
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      info_we_o[p]            = 1'b0;
      info_waddr_o[p]         = index_of(pc_q);
      info_wdata_o[p]         = info_i[p];
      info_wdata_o[p].history = {info_i[p].history[HIST_LEN-2:0], jump[p]};
      if (corr_i.need_update && corr_i.miss && (corr_i.pc[2] == p[0])) begin
        info_we_o[p]                = 1'b1;
        info_waddr_o[p]             = index_of(corr_i.pc);
        info_wdata_o[p].target_type = corr_i.true_type;
        info_wdata_o[p].cond        = corr_i.true_cond;
        info_wdata_o[p].history     = {corr_i.history[HIST_LEN-2:0], corr_i.true_taken};
        info_wdata_o[p].tag         = tag_of(corr_i.pc);
      end else if (hit[p] && bundle_fire && mask_o[p]) begin
        info_we_o[p] = 1'b1;
      end
    end
  end

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      predict_o[p].taken       = slot_taken[p];
      predict_o[p].tid         = tid_q;
      predict_o[p].predict_pc  = npc_o;
      predict_o[p].cnt         = cnt_i[p];
      predict_o[p].history     = info_i[p].history;
      predict_o[p].target_type = info_i[p].target_type;
      predict_o[p].cond        = info_i[p].cond;
      predict_o[p].ras_ptr     = ras_ptr_i;
    end
  end

  // redirect drops the bundle and lands on the target once accepted
  a_redirect_flush: assert property (
    @(posedge clk) disable iff (!rst_n)
    corr_i.redirect |-> !valid_o ##1 (!$past(ready_i) || pc_o == $past(corr_i.true_target))
  );

endmodule

`default_nettype wire

// ==== verilog/branch_predictor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_top
  import bpu_cfg_pkg::*, bpu_types_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ready_i,
  input  bpu_correct_t       corr_i,
  output logic               valid_o,
  output logic [31:0]        pc_o,
  output logic [1:0]         mask_o,
  output bpu_predict_t [1:0] predict_o
);

  logic [31:0]               npc;
  logic                      rd_en;
  logic [INDEX_LEN-1:0]      rd_addr;
  logic [INDEX_LEN-1:0]      corr_addr;
  logic                      tgt_wr_ok;
  logic [1:0][31:0]          target;
  branch_info_t [1:0]        info_rdata;
  logic [1:0][HIST_LEN-1:0]  hist;
  logic [1:0][1:0]           cnt;
  logic [1:0]                info_we;
  logic [1:0][INDEX_LEN-1:0] info_waddr;
  branch_info_t [1:0]        info_wdata;
  logic                      push;
  logic                      pop;
  logic [31:0]               push_addr;
  logic [31:0]               ras_top;
  logic [RAS_PTR_LEN-1:0]    ras_ptr;

  assign rd_addr   = index_of(npc);
  assign corr_addr = index_of(corr_i.pc);
  // only direct branches and calls have a stored target
  assign tgt_wr_ok = corr_i.need_update &&
                     ((corr_i.true_type == TGT_IMM) || (corr_i.true_type == TGT_CALL));

  for (genvar p = 0; p < 2; p++) begin : g_slot
    logic [29:0] target_word;

    bpu_table #(
      .payload_t (logic [29:0])
    ) u_target_table (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (target_word),
      .wr_en_i   (tgt_wr_ok && (corr_i.pc[2] == 1'(p))),
      .wr_addr_i (corr_addr),
      .wr_data_i (corr_i.true_target[31:2]),
      .hold_i    (1'b0)
    );

    // targets are word aligned
    assign target[p] = {target_word, 2'b00};

    bpu_table #(
      .payload_t (branch_info_t)
    ) u_info_table (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (info_rdata[p]),
      .wr_en_i   (info_we[p]),
      .wr_addr_i (info_waddr[p]),
      .wr_data_i (info_wdata[p]),
      .hold_i    (corr_i.redirect)
    );
  end

  pattern_table u_pattern_table (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_pc_i   (pc_o),
    .rd_hist_i (hist),
    .cnt_o     (cnt),
    .corr_i    (corr_i)
  );

  return_stack u_return_stack (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (push),
    .pop_i       (pop),
    .push_addr_i (push_addr),
    .corr_i      (corr_i),
    .top_o       (ras_top),
    .ptr_o       (ras_ptr)
  );

  fetch_pc_ctrl u_fetch_pc_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .ready_i      (ready_i),
    .corr_i       (corr_i),
    .target_i     (target),
    .info_i       (info_rdata),
    .cnt_i        (cnt),
    .ras_top_i    (ras_top),
    .ras_ptr_i    (ras_ptr),
    .npc_o        (npc),
    .rd_en_o      (rd_en),
    .hist_o       (hist),
    .info_we_o    (info_we),
    .info_waddr_o (info_waddr),
    .info_wdata_o (info_wdata),
    .push_o       (push),
    .pop_o        (pop),
    .push_addr_o  (push_addr),
    .valid_o      (valid_o),
    .pc_o         (pc_o),
    .mask_o       (mask_o),
    .predict_o    (predict_o)
  );

endmodule

`default_nettype wire

// ==== sim/branch_predictor_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_tb
  import bpu_cfg_pkg::*, bpu_types_pkg::*;
;

  typedef struct packed {
    logic [3:0]             test;
    logic                   ready;
    bpu_correct_t           corr;
    logic                   chk;
    logic                   valid;
    logic [31:0]            pc;
    logic [31:0]            npc;
    logic [1:0]             mask;
    logic [1:0]             taken;
    logic [RAS_PTR_LEN-1:0] ras_ptr;
  } step_t;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               ready_i;
  bpu_correct_t       corr_i;
  logic               valid_o;
  logic [31:0]        pc_o;
  logic [1:0]         mask_o;
  bpu_predict_t [1:0] predict_o;

  step_t steps [$];
  int    checks = 0;
  int    errors = 0;
  int    test_errors = 0;
  int    cycles = 0;
  int    cycle_limit = 0;
  string test_name [7] = '{"", "sequential fetch", "redirect", "unconditional branch",
                           "conditional branch", "call and return", "stack repair"};

  // reference model state
  logic [31:0]            m_pc;
  branch_info_t           m_info [2][INDEX_DEPTH];
  logic [29:0]            m_tgt [2][INDEX_DEPTH];
  branch_info_t           m_rinfo [2];
  logic [29:0]            m_rtgt [2];
  logic [1:0]             m_cnt [CNT_DEPTH];
  logic [31:0]            m_stack [RAS_DEPTH];
  logic [RAS_PTR_LEN-1:0] m_ptr;
  logic [31:0]            m_top;

  branch_predictor_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ready_i   (ready_i),
    .corr_i    (corr_i),
    .valid_o   (valid_o),
    .pc_o      (pc_o),
    .mask_o    (mask_o),
    .predict_o (predict_o)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: run went past %0d cycles without finishing", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [INDEX_LEN-1:0] table_index(input logic [31:0] pc);
    return pc[8:3] ^ pc[14:9];
  endfunction

  // saturating 2-bit counter
  function automatic logic [1:0] count_toward(input logic [1:0] cnt, input logic taken);
    if (taken) begin
      return (cnt == 2'b11) ? cnt : cnt + 2'd1;
    end
    return (cnt == 2'b00) ? cnt : cnt - 2'd1;
  endfunction

  function automatic bpu_correct_t redirect_corr(input logic [31:0] target);
    bpu_correct_t c;
    c             = '0;
    c.redirect    = 1'b1;
    c.true_target = target;
    return c;
  endfunction

  function automatic bpu_correct_t train_corr(input logic [31:0] pc,
      input logic [31:0] target, input bpu_target_e kind, input logic cond,
      input logic taken, input logic miss, input logic [1:0] cnt);
    bpu_correct_t c;
    c             = '0;
    c.need_update = 1'b1;
    c.miss        = miss;
    c.pc          = pc;
    c.true_target = target;
    c.true_type   = kind;
    c.true_cond   = cond;
    c.true_taken  = taken;
    c.cnt         = cnt;
    return c;
  endfunction

  // tables start out empty
  task automatic reset_model();
    m_pc  = RESET_PC;
    m_ptr = '0;
    m_top = '0;
    for (int p = 0; p < 2; p++) begin
      m_rinfo[p] = '0;
      m_rtgt[p]  = '0;
      for (int i = 0; i < INDEX_DEPTH; i++) begin
        m_info[p][i] = '0;
        m_tgt[p][i]  = '0;
      end
    end
    for (int i = 0; i < CNT_DEPTH; i++) begin
      m_cnt[i] = 2'b00;
    end
    for (int i = 0; i < RAS_DEPTH; i++) begin
      m_stack[i] = '0;
    end
  endtask

  // one cycle of the model, records the expected bundle
  task automatic add_step(input int test, input logic ready, input bpu_correct_t c,
                          input logic chk);
    step_t        s;
    logic [1:0]   hit;
    logic [1:0]   jump;
    logic [1:0]   cnt [2];
    logic [1:0]   mask;
    logic [1:0]   taken;
    logic [31:0]  base;
    logic [31:0]  npc;
    logic         fire;
    bpu_target_e  jt;
    branch_info_t wr;
    branch_info_t rd_info [2];
    logic [29:0]  rd_tgt [2];
    logic [31:0]  old_top;

    base = {m_pc[31:3], 3'b000};
    for (int p = 0; p < 2; p++) begin
      hit[p]  = (m_rinfo[p].target_type != TGT_NPC) && (m_rinfo[p].tag == m_pc[18:12]);
      cnt[p]  = m_cnt[{m_pc[6:3], m_rinfo[p].history}];
      jump[p] = hit[p] && ((m_rinfo[p].target_type != TGT_IMM) || !m_rinfo[p].cond ||
                           cnt[p][1]);
    end
    npc   = base + 32'd8;
    mask  = {1'b1, !m_pc[2]};
    taken = 2'b00;
    jt    = TGT_NPC;
    if (jump[0] && !m_pc[2]) begin
      taken   = 2'b01;
      mask[1] = 1'b0;
    end else if (jump[1]) begin
      taken = 2'b10;
    end
    for (int p = 0; p < 2; p++) begin
      if (taken[p]) begin
        jt  = m_rinfo[p].target_type;
        npc = (jt == TGT_RETURN) ? m_top : {m_rtgt[p], 2'b00};
      end
    end
    if (c.redirect) begin
      npc = c.true_target;
    end

    s.test    = 4'(test);
    s.ready   = ready;
    s.corr    = c;
    s.chk     = chk;
    s.valid   = !c.redirect;
    s.pc      = m_pc;
    s.npc     = npc;
    s.mask    = mask;
    s.taken   = taken;
    s.ras_ptr = m_ptr;
    steps.push_back(s);

    fire = !c.redirect && ready;

    // registered reads see the tables as they were before this cycle
    for (int p = 0; p < 2; p++) begin
      rd_info[p] = m_info[p][table_index(npc)];
      rd_tgt[p]  = m_tgt[p][table_index(npc)];
    end
    old_top = m_stack[m_ptr];

    for (int p = 0; p < 2; p++) begin
      if (c.need_update && c.miss && (c.pc[2] == (p == 1))) begin
        wr.target_type = c.true_type;
        wr.cond        = c.true_cond;
        wr.history     = {c.history[HIST_LEN-2:0], c.true_taken};
        wr.tag         = c.pc[18:12];
        m_info[p][table_index(c.pc)] = wr;
      end else if (hit[p] && fire && mask[p]) begin
        wr         = m_rinfo[p];
        wr.history = {m_rinfo[p].history[HIST_LEN-2:0], jump[p]};
        m_info[p][table_index(m_pc)] = wr;
      end
    end
    if (c.need_update && (c.true_type == TGT_IMM || c.true_type == TGT_CALL)) begin
      m_tgt[c.pc[2]][table_index(c.pc)] = c.true_target[31:2];
    end
    if (c.need_update && c.true_cond) begin
      m_cnt[{c.pc[6:3], c.history}] = count_toward(c.cnt, c.true_taken);
    end

    if (c.miss || c.ras_repair) begin
      m_ptr = c.ras_ptr;
      if (c.true_type == TGT_CALL) begin
        m_stack[c.ras_ptr] = c.pc + 32'd4;
      end
    end else if (fire && jt == TGT_CALL) begin
      m_stack[m_ptr + 3'd1] = base + (taken[0] ? 32'd4 : 32'd8);
      m_ptr = m_ptr + 3'd1;
    end else if (fire && jt == TGT_RETURN) begin
      m_ptr = m_ptr - 3'd1;
    end
    m_top = old_top;

    if (ready) begin
      m_rinfo = rd_info;
      m_rtgt  = rd_tgt;
      m_pc    = npc;
    end else if (c.redirect) begin
      m_rinfo = rd_info;
    end
  endtask

  task automatic build_steps();
    logic [31:0] x_pc = 32'h1c000140;
    logic [31:0] t_pc = 32'h1c000180;
    logic [31:0] c_pc = 32'h1c000100;
    logic [31:0] d_pc = 32'h1c0001c0;
    logic [31:0] a_pc = 32'h1c000040;
    logic [31:0] f_pc = 32'h1c000080;
    logic [31:0] r_pc = 32'h1c000088;
    bpu_correct_t c;

    for (int i = 0; i < 16; i++) begin
      add_step(1, ($urandom % 4) != 0, '0, 1'b1);
    end

    // target in slot 1, then a stall
    add_step(2, 1'b1, redirect_corr(32'h1c000024), 1'b1);
    add_step(2, 1'b1, '0, 1'b1);
    add_step(2, 1'b0, '0, 1'b1);
    add_step(2, 1'b1, '0, 1'b1);
    add_step(2, 1'b1, '0, 1'b1);

    add_step(3, 1'b1, train_corr(x_pc, t_pc, TGT_IMM, 1'b0, 1'b1, 1'b1, 2'b00), 1'b0);
    add_step(3, 1'b1, redirect_corr(x_pc), 1'b1);
    repeat (3) add_step(3, 1'b1, '0, 1'b1);

    // falls through first, then two taken updates move the counter to 10
    add_step(4, 1'b1, train_corr(c_pc, d_pc, TGT_IMM, 1'b1, 1'b0, 1'b1, 2'b00), 1'b0);
    add_step(4, 1'b1, redirect_corr(c_pc), 1'b1);
    repeat (2) add_step(4, 1'b1, '0, 1'b1);
    add_step(4, 1'b1, train_corr(c_pc, d_pc, TGT_IMM, 1'b1, 1'b1, 1'b0, 2'b00), 1'b0);
    add_step(4, 1'b1, train_corr(c_pc, d_pc, TGT_IMM, 1'b1, 1'b1, 1'b0, 2'b01), 1'b0);
    add_step(4, 1'b1, redirect_corr(c_pc), 1'b1);
    repeat (3) add_step(4, 1'b1, '0, 1'b1);

    // call in slot 1 of A, return at R right after F
    add_step(5, 1'b1, train_corr(a_pc + 32'd4, f_pc, TGT_CALL, 1'b0, 1'b1, 1'b1, 2'b00),
             1'b0);
    add_step(5, 1'b1, train_corr(r_pc, a_pc + 32'd8, TGT_RETURN, 1'b0, 1'b1, 1'b1, 2'b00),
             1'b0);
    add_step(5, 1'b1, redirect_corr(a_pc), 1'b1);
    repeat (4) add_step(5, 1'b1, '0, 1'b1);

    add_step(6, 1'b1, redirect_corr(a_pc), 1'b1);
    add_step(6, 1'b1, '0, 1'b1);
    c            = redirect_corr(32'h1c000010);
    c.ras_repair = 1'b1;
    c.ras_ptr    = '0;
    add_step(6, 1'b1, c, 1'b1);
    repeat (2) add_step(6, 1'b1, '0, 1'b1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_step(input step_t s);
    check_value("valid_o", 32'(s.valid), 32'(valid_o));
    check_value("pc_o", s.pc, pc_o);
    check_value("mask_o", 32'(s.mask), 32'(mask_o));
    check_value("predict_o.taken", 32'(s.taken),
                32'({predict_o[1].taken, predict_o[0].taken}));
    check_value("predict_o[0].predict_pc", s.npc, predict_o[0].predict_pc);
    check_value("predict_o[1].predict_pc", s.npc, predict_o[1].predict_pc);
    check_value("predict_o.ras_ptr", 32'(s.ras_ptr), 32'(predict_o[0].ras_ptr));
  endtask

  task automatic report_test(input int t);
    $display("test %0d %s: %s, %0d errors", t, test_name[t],
             (test_errors == 0) ? "ok" : "failed", test_errors);
    test_errors = 0;
  endtask

  initial begin
    rst_n   = 1'b0;
    ready_i = 1'b1;
    corr_i  = '0;
    void'($urandom(32'h40c55ee9));
    reset_model();
    build_steps();
    cycle_limit = 2 * steps.size() + 50;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < steps.size(); i++) begin
      ready_i <= steps[i].ready;
      corr_i  <= steps[i].corr;
      // outputs settle well before the falling edge
      @(negedge clk);
      if (steps[i].chk) begin
        check_step(steps[i]);
      end
      if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
        report_test(steps[i].test);
      end
      @(posedge clk);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== branch_predictor_top.f ====
verilog/bpu_cfg_pkg.sv
verilog/bpu_types_pkg.sv
verilog/bpu_table.sv
verilog/pattern_table.sv
verilog/return_stack.sv
verilog/fetch_pc_ctrl.sv
verilog/branch_predictor_top.sv
sim/branch_predictor_tb.sv

// ==== Makefile ====
TOP := branch_predictor_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -Mdir obj_dir \
		-f branch_predictor_top.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
